//--- hdl/arrayPkg.sv
//********************************************************************
// Shared sizes, opcodes and result codes of the array memory
// Opcode values past opGreater are decoded as nop
//********************************************************************
package arrayPkg;

  localparam int addressBits = 3;                 // Bits in an array number
  localparam int arrayCount  = 2 ** addressBits;  // Arrays held
  localparam int indexBits   = 3;                 // Bits in an element index
  localparam int arrayLength = 2 ** indexBits;    // Elements per array
  localparam int sizeBits    = indexBits + 1;     // Holds a full size of arrayLength
  localparam int dataBits    = 16;                // Element width

  typedef enum logic [4:0] {
    opNop = 5'd0,  // Idle cycle
    opClear,       // Drop every allocation
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAlloc,
    opFree,
    opAdd,         // Returns the new value
    opAddAfter,    // Returns the old value
    opSub,
    opSubAfter,
    opShiftLeft,
    opShiftRight,
    opNotLogical,
    opNot,
    opOr,
    opXor,
    opAnd,
    opIndex,       // Last match plus one
    opLess,
    opGreater
  } arrayOp_e;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,  // Array number never issued
    errFreed,         // Issued but released
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } arrayError_e;

endpackage

//--- hdl/arrayAllocator.sv
//********************************************************************
// Issues array numbers, reusing freed ones last freed first
// Release is only valid for a live array, so the stack never overflows
//********************************************************************
`timescale 1ns/1ns

module arrayAllocator (
  input  logic                             clock,
  input  logic                             arstN,
  input  logic [arrayPkg::addressBits-1:0] array,
  input  logic                             allocate,
  input  logic                             releaseArray,
  input  logic                             clearAll,
  output logic                             isLive,
  output logic                             isIssued,
  output logic                             canAllocate,
  output logic [arrayPkg::addressBits-1:0] nextArray
);

  logic [arrayPkg::addressBits:0]   issuedCount;                       // Arrays handed out so far
  logic [arrayPkg::addressBits:0]   freeTop;                           // Entries on the free stack
  logic [arrayPkg::addressBits-1:0] freeStack [arrayPkg::arrayCount];
  logic [arrayPkg::arrayCount-1:0]  allocated;
  logic [arrayPkg::addressBits-1:0] stackTop;

  assign stackTop    = (arrayPkg::addressBits)'(freeTop - 1'b1);
  assign isIssued    = {1'b0, array} < issuedCount;
  assign isLive      = isIssued && allocated[array];
  assign canAllocate = (freeTop != '0) ||
                       (issuedCount < (arrayPkg::addressBits + 1)'(arrayPkg::arrayCount));
  assign nextArray   = (freeTop != '0) ? freeStack[stackTop]
                                       : issuedCount[arrayPkg::addressBits-1:0];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      issuedCount <= '0;
      freeTop     <= '0;
      allocated   <= '0;
    end else if (clearAll) begin
      issuedCount <= '0;
      freeTop     <= '0;
      allocated   <= '0;
    end else if (allocate) begin
      if (freeTop != '0) begin
        freeTop <= freeTop - 1'b1;                                     // Pop a reused number
      end else begin
        issuedCount <= issuedCount + 1'b1;
      end
      allocated[nextArray] <= 1'b1;
    end else if (releaseArray) begin
      freeTop          <= freeTop + 1'b1;
      allocated[array] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray) begin
      freeStack[freeTop[arrayPkg::addressBits-1:0]] <= array;
    end
  end

endmodule

//--- hdl/arraySizeTable.sv
//********************************************************************
// One size per array, loaded whole by the controller
//********************************************************************
`timescale 1ns/1ns

module arraySizeTable (
  input  logic                             clock,
  input  logic                             arstN,
  input  logic [arrayPkg::addressBits-1:0] array,
  input  logic                             sizeLoad,
  input  logic [arrayPkg::sizeBits-1:0]    sizeNext,
  output logic [arrayPkg::sizeBits-1:0]    size
);

  logic [arrayPkg::sizeBits-1:0] sizes [arrayPkg::arrayCount];

  assign size = sizes[array];

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      sizes <= '{default: '0};                                         // Every array empty
    end else if (sizeLoad) begin
      sizes[array] <= sizeNext;
    end
  end

endmodule

//--- hdl/elementStore.sv
//********************************************************************
// Element storage, one write port and a whole-row read port
// Contents come up undefined after power-on
//********************************************************************
`timescale 1ns/1ns

module elementStore (
  input  logic                                                  clock,
  input  logic [arrayPkg::addressBits-1:0]                      array,
  input  logic [arrayPkg::indexBits-1:0]                        index,
  input  logic                                                  writeEnable,
  input  logic [arrayPkg::indexBits-1:0]                        writeIndex,
  input  logic [arrayPkg::dataBits-1:0]                         writeData,
  output logic [arrayPkg::dataBits-1:0]                         element,
  output logic [arrayPkg::arrayLength-1:0][arrayPkg::dataBits-1:0] row
);

  logic [arrayPkg::arrayLength-1:0][arrayPkg::dataBits-1:0] memory [arrayPkg::arrayCount];

  assign row     = memory[array];
  assign element = row[index];

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][writeIndex] <= writeData;
    end
  end

endmodule

//--- hdl/elementAlu.sv
//********************************************************************
// New element value for the in-place operations
// Shifts by dataBits or more give zero
//********************************************************************
`timescale 1ns/1ns

module elementAlu (
  input  arrayPkg::arrayOp_e              action,
  input  logic [arrayPkg::dataBits-1:0]   element,
  input  logic [arrayPkg::dataBits-1:0]   in,
  output logic [arrayPkg::dataBits-1:0]   aluResult
);

  always_comb begin
    case (action)
      arrayPkg::opAdd,
      arrayPkg::opAddAfter:   aluResult = element + in;
      arrayPkg::opSub,
      arrayPkg::opSubAfter:   aluResult = element - in;
      arrayPkg::opShiftLeft:  aluResult = element << in;
      arrayPkg::opShiftRight: aluResult = element >> in;
      arrayPkg::opNotLogical: aluResult = (arrayPkg::dataBits)'(element == '0);
      arrayPkg::opNot:        aluResult = ~element;
      arrayPkg::opOr:         aluResult = element | in;
      arrayPkg::opXor:        aluResult = element ^ in;
      arrayPkg::opAnd:        aluResult = element & in;
      default:                aluResult = element;                      // Not written back
    endcase
  end

endmodule

//--- hdl/arraySearch.sv
//********************************************************************
// Parallel scan of one row, elements at or above size are ignored
//********************************************************************
`timescale 1ns/1ns

module arraySearch (
  input  logic [arrayPkg::arrayLength-1:0][arrayPkg::dataBits-1:0] row,
  input  logic [arrayPkg::sizeBits-1:0]                          size,
  input  logic [arrayPkg::dataBits-1:0]                          in,
  output logic [arrayPkg::sizeBits-1:0]                          indexOf,
  output logic [arrayPkg::sizeBits-1:0]                          lessCount,
  output logic [arrayPkg::sizeBits-1:0]                          greaterCount
);

  always_comb begin
    indexOf      = '0;
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < arrayPkg::arrayLength; i++) begin
      if ((arrayPkg::sizeBits)'(i) < size) begin
        if (row[i] == in) begin
          indexOf = (arrayPkg::sizeBits)'(i + 1);                      // Later matches win
        end
        if (row[i] < in) begin
          lessCount = lessCount + 1'b1;
        end
        if (row[i] > in) begin
          greaterCount = greaterCount + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/arrayController.sv
//********************************************************************
// Decodes one action per cycle, checks access, registers out and error
// writeIndex also addresses the store read, so pop sees the new top
//********************************************************************
`timescale 1ns/1ns

module arrayController (
  input  logic                             clock,
  input  logic                             arstN,
  input  arrayPkg::arrayOp_e               action,
  input  logic [arrayPkg::addressBits-1:0] array,
  input  logic [arrayPkg::indexBits-1:0]   index,
  input  logic [arrayPkg::dataBits-1:0]    in,
  input  logic                             isLive,
  input  logic                             isIssued,
  input  logic                             canAllocate,
  input  logic [arrayPkg::addressBits-1:0] nextArray,
  input  logic [arrayPkg::sizeBits-1:0]    size,
  input  logic [arrayPkg::dataBits-1:0]    element,
  input  logic [arrayPkg::dataBits-1:0]    aluResult,
  input  logic [arrayPkg::sizeBits-1:0]    indexOf,
  input  logic [arrayPkg::sizeBits-1:0]    lessCount,
  input  logic [arrayPkg::sizeBits-1:0]    greaterCount,
  output logic                             allocate,
  output logic                             releaseArray,
  output logic                             clearAll,
  output logic                             sizeLoad,
  output logic [arrayPkg::sizeBits-1:0]    sizeNext,
  output logic                             writeEnable,
  output logic [arrayPkg::indexBits-1:0]   writeIndex,
  output logic [arrayPkg::dataBits-1:0]    writeData,
  output logic [arrayPkg::dataBits-1:0]    out,
  output arrayPkg::arrayError_e            error
);

  logic                          needsAccess;
  logic                          readType;
  logic                          inBounds;
  arrayPkg::arrayError_e         accessError;
  arrayPkg::arrayError_e         errorNext;
  logic [arrayPkg::dataBits-1:0] outNext;

  assign needsAccess = action inside {[arrayPkg::opWrite : arrayPkg::opPop],
                                      [arrayPkg::opFree : arrayPkg::opGreater]};
  assign readType    = action inside {arrayPkg::opRead, [arrayPkg::opAdd : arrayPkg::opAnd]};
  assign inBounds    = {1'b0, index} < size;
  assign accessError = !isIssued             ? arrayPkg::errNotAllocated :
                       !isLive               ? arrayPkg::errFreed :
                       (readType && !inBounds) ? arrayPkg::errOutOfBounds : arrayPkg::errNone;

  always_comb begin
    allocate     = 1'b0;
    releaseArray = 1'b0;
    clearAll     = 1'b0;
    sizeLoad     = 1'b0;
    sizeNext     = size;
    writeEnable  = 1'b0;
    writeIndex   = index;
    writeData    = aluResult;
    outNext      = out;
    errorNext    = arrayPkg::errNone;
    if (action == arrayPkg::opNop) begin
      errorNext = error;                                                // Hold last result
    end else if (needsAccess && accessError != arrayPkg::errNone) begin
      errorNext = accessError;
    end else begin
      case (action)
        arrayPkg::opClear: clearAll = 1'b1;
        arrayPkg::opAlloc: begin
          if (canAllocate) begin
            allocate = 1'b1;
            sizeLoad = 1'b1;                                            // Size table sees nextArray
            sizeNext = '0;
            outNext  = (arrayPkg::dataBits)'(nextArray);
          end else begin
            errorNext = arrayPkg::errOutOfMemory;
          end
        end
        arrayPkg::opFree: begin
          releaseArray = 1'b1;
          outNext      = (arrayPkg::dataBits)'(array);                 // Echo the freed number
        end
        arrayPkg::opWrite: begin
          writeEnable = 1'b1;
          writeData   = in;
          outNext     = in;
          if (!inBounds) begin
            sizeLoad = 1'b1;                                            // Grow to cover index
            sizeNext = {1'b0, index} + 1'b1;
          end
        end
        arrayPkg::opRead: outNext = element;
        arrayPkg::opSize: outNext = (arrayPkg::dataBits)'(size);
        arrayPkg::opPush: begin
          if (size[arrayPkg::indexBits]) begin                          // Top bit set means full
            errorNext = arrayPkg::errFull;
          end else begin
            writeEnable = 1'b1;
            writeIndex  = size[arrayPkg::indexBits-1:0];
            writeData   = in;
            sizeLoad    = 1'b1;
            sizeNext    = size + 1'b1;
          end
        end
        arrayPkg::opPop: begin
          if (size == '0) begin
            errorNext = arrayPkg::errEmpty;
          end else begin
            sizeLoad   = 1'b1;
            sizeNext   = size - 1'b1;
            writeIndex = sizeNext[arrayPkg::indexBits-1:0];             // Read slot of the new top
            outNext    = element;
          end
        end
        arrayPkg::opIndex:   outNext = (arrayPkg::dataBits)'(indexOf);
        arrayPkg::opLess:    outNext = (arrayPkg::dataBits)'(lessCount);
        arrayPkg::opGreater: outNext = (arrayPkg::dataBits)'(greaterCount);
        arrayPkg::opAddAfter,
        arrayPkg::opSubAfter: begin
          writeEnable = 1'b1;
          outNext     = element;                                        // Old value out
        end
        arrayPkg::opAdd, arrayPkg::opSub, arrayPkg::opShiftLeft, arrayPkg::opShiftRight,
        arrayPkg::opNotLogical, arrayPkg::opNot, arrayPkg::opOr, arrayPkg::opXor,
        arrayPkg::opAnd: begin
          writeEnable = 1'b1;
          outNext     = aluResult;
        end
        default: errorNext = error;                                     // Unused codes act as nop
      endcase
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      out   <= '0;
      error <= arrayPkg::errNone;
    end else begin
      out   <= outNext;
      error <= errorNext;
    end
  end

endmodule

//--- hdl/arrayMemory.sv
//********************************************************************
// Array memory top that samples and completes one action per clock
//********************************************************************
`timescale 1ns/1ns

module arrayMemory (
  input  logic                             clock,
  input  logic                             arstN,
  input  arrayPkg::arrayOp_e               action,
  input  logic [arrayPkg::addressBits-1:0] array,
  input  logic [arrayPkg::indexBits-1:0]   index,
  input  logic [arrayPkg::dataBits-1:0]    in,
  output logic [arrayPkg::dataBits-1:0]    out,
  output arrayPkg::arrayError_e            error
);

  logic                                                      allocate;
  logic                                                      releaseArray;
  logic                                                      clearAll;
  logic                                                      isLive;
  logic                                                      isIssued;
  logic                                                      canAllocate;
  logic [arrayPkg::addressBits-1:0]                          nextArray;
  logic [arrayPkg::addressBits-1:0]                          sizeArray;
  logic                                                      sizeLoad;
  logic                                                      writeEnable;
  logic [arrayPkg::sizeBits-1:0]                             sizeNext;
  logic [arrayPkg::sizeBits-1:0]                             size;
  logic [arrayPkg::indexBits-1:0]                            slotIndex;
  logic [arrayPkg::dataBits-1:0]                             writeData;
  logic [arrayPkg::dataBits-1:0]                             element;
  logic [arrayPkg::dataBits-1:0]                             aluResult;
  logic [arrayPkg::arrayLength-1:0][arrayPkg::dataBits-1:0]  row;
  logic [arrayPkg::sizeBits-1:0]                             indexOf;
  logic [arrayPkg::sizeBits-1:0]                             lessCount;
  logic [arrayPkg::sizeBits-1:0]                             greaterCount;

  // Alloc clears the size of the array it hands out
  assign sizeArray = (action == arrayPkg::opAlloc) ? nextArray : array;

  arrayController controller_i (
    .clock, .arstN, .action, .array, .index, .in,
    .isLive, .isIssued, .canAllocate, .nextArray, .size, .element, .aluResult,
    .indexOf, .lessCount, .greaterCount,
    .allocate, .releaseArray, .clearAll, .sizeLoad, .sizeNext, .writeEnable,
    .writeIndex(slotIndex), .writeData, .out, .error
  );

  arrayAllocator allocator_i (
    .clock, .arstN, .array, .allocate, .releaseArray, .clearAll,
    .isLive, .isIssued, .canAllocate, .nextArray
  );

  arraySizeTable sizeTable_i (
    .clock, .arstN, .array(sizeArray), .sizeLoad, .sizeNext, .size
  );

  elementStore store_i (
    .clock, .array, .index(slotIndex), .writeEnable, .writeIndex(slotIndex),
    .writeData, .element, .row
  );

  elementAlu alu_i (.action, .element, .in, .aluResult);

  arraySearch search_i (.row, .size, .in, .indexOf, .lessCount, .greaterCount);

endmodule

//--- verif/tbArrayMemory.sv
//********************************************************************
// Trace-driven testbench, one trace line per clock cycle
// Trace is read from verif/arrayTrace.txt relative to the project root
//********************************************************************
`timescale 1ns/1ns

module tbArrayMemory;

  localparam int    clockPeriod = 4;
  localparam int    maxLines    = 400;                    // Upper bound on trace length
  localparam string traceFile   = "verif/arrayTrace.txt";

  logic                             clock;
  logic                             arstN;
  arrayPkg::arrayOp_e               action;
  logic [arrayPkg::addressBits-1:0] array;
  logic [arrayPkg::indexBits-1:0]   index;
  logic [arrayPkg::dataBits-1:0]    in;
  logic [arrayPkg::dataBits-1:0]    out;
  arrayPkg::arrayError_e            error;

  arrayMemory dut_i (
    .clock, .arstN, .action, .array, .index, .in, .out, .error
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic checkValue(input string name, input logic [arrayPkg::dataBits-1:0] actual,
                            input logic [arrayPkg::dataBits-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] time %0t ns, %s: got %h, expected %h", $time, name, actual, expected);
      reportFailure("value mismatch against the trace");
    end
  endtask

  // Blank lines and lines opening with # carry no stimulus
  function automatic bit isDataLine(input string line);
    if (line.len() <= 1) begin
      return 1'b0;
    end
    return line.substr(0, 0) != "#";
  endfunction

  initial begin : runTrace
    int                            fd;
    int                            lineNumber;
    int                            fields;
    int                            actionCode;
    int                            arrayCode;
    int                            indexCode;
    int                            errorCode;
    int                            checkLine;
    logic [arrayPkg::dataBits-1:0] inValue;
    logic [arrayPkg::dataBits-1:0] outValue;
    logic [arrayPkg::dataBits-1:0] expectOut;
    logic [arrayPkg::dataBits-1:0] expectError;
    string                         line;
    bit                            pending;
    bit                            done;

    action = arrayPkg::opNop;
    array  = '0;
    index  = '0;
    in     = '0;
    arstN  = 1'b0;
    pending     = 1'b0;
    done        = 1'b0;
    lineNumber  = 0;
    checkLine   = 0;
    expectOut   = '0;
    expectError = '0;

    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      reportFailure("could not open the trace file verif/arrayTrace.txt");
    end

    repeat (3) @(posedge clock);
    #1 arstN = 1'b1;

    while (!done) begin
      if ($fgets(line, fd) == 0) begin
        done = 1'b1;                                          // End of trace
      end else begin
        lineNumber++;
        if (lineNumber > maxLines) begin
          reportFailure("trace file is longer than the line limit");
        end
        if (isDataLine(line)) begin
          fields = $sscanf(line, "%d %d %d %h %h %d", actionCode, arrayCode, indexCode,
                           inValue, outValue, errorCode);
          if (fields != 6) begin
            reportFailure($sformatf("trace line %0d is malformed", lineNumber));
          end
          @(posedge clock);
          #1;
          if (pending) begin                                  // Result of the previous line
            checkValue($sformatf("out (trace line %0d)", checkLine), out, expectOut);
            checkValue($sformatf("error (trace line %0d)", checkLine),
                       {13'd0, error}, expectError);
          end
          action = arrayPkg::arrayOp_e'(actionCode[4:0]);
          array  = arrayCode[arrayPkg::addressBits-1:0];
          index  = indexCode[arrayPkg::indexBits-1:0];
          in     = inValue;
          expectOut   = outValue;
          expectError = 16'(errorCode);
          checkLine   = lineNumber;
          pending     = 1'b1;
        end
      end
    end

    @(posedge clock);
    #1;
    if (pending) begin
      checkValue($sformatf("out (trace line %0d)", checkLine), out, expectOut);
      checkValue($sformatf("error (trace line %0d)", checkLine), {13'd0, error}, expectError);
    end
    action = arrayPkg::opNop;
    $fclose(fd);
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verif/arrayTrace.txt
# action array index in(hex) expectedOut(hex) expectedError, all codes as decimal numbers
# actions 0 nop 1 clear 2 write 3 read 4 size 5 push 6 pop 7 alloc 8 free 9..19 element ops
0 0 0 0000 0000 0
3 0 0 0000 0000 1
7 0 0 0000 0000 0
7 0 0 0000 0001 0
7 0 0 0000 0002 0
7 0 0 0000 0003 0
7 0 0 0000 0004 0
7 0 0 0000 0005 0
7 0 0 0000 0006 0
7 0 0 0000 0007 0
7 0 0 0000 0007 6
8 3 0 0000 0003 0
8 5 0 0000 0005 0
7 0 0 0000 0005 0
7 0 0 0000 0003 0
8 2 0 0000 0002 0
2 2 0 1234 0002 2
8 2 0 0000 0002 2
1 0 0 0000 0002 0
7 0 0 0000 0000 0
7 0 0 0000 0001 0
3 2 0 0000 0001 1
# write, size, bounds, then fill and drain array 1
2 0 5 00aa 00aa 0
4 0 0 0000 0006 0
3 0 6 0000 0006 3
3 0 5 0000 00aa 0
5 1 0 0011 00aa 0
5 1 0 0022 00aa 0
5 1 0 0033 00aa 0
5 1 0 0044 00aa 0
5 1 0 0055 00aa 0
5 1 0 0066 00aa 0
5 1 0 0077 00aa 0
5 1 0 0088 00aa 0
5 1 0 0099 00aa 4
4 1 0 0000 0008 0
6 1 0 0000 0088 0
6 1 0 0000 0077 0
6 1 0 0000 0066 0
6 1 0 0000 0055 0
6 1 0 0000 0044 0
6 1 0 0000 0033 0
6 1 0 0000 0022 0
6 1 0 0000 0011 0
6 1 0 0000 0011 5
# in-place element operations on array 0 index 0
2 0 0 00f0 00f0 0
9 0 0 0010 0100 0
10 0 0 0001 0100 0
3 0 0 0000 0101 0
11 0 0 0001 0100 0
12 0 0 0100 0100 0
3 0 0 0000 0000 0
15 0 0 0000 0001 0
15 0 0 0000 0000 0
16 0 0 0000 ffff 0
19 0 0 0ff0 0ff0 0
17 0 0 000f 0fff 0
18 0 0 00ff 0f00 0
13 0 0 0004 f000 0
14 0 0 0008 00f0 0
13 0 0 0010 0000 0
# search over array 1, stale elements above the size
5 1 0 0005 0000 0
5 1 0 0003 0000 0
5 1 0 0005 0000 0
5 1 0 0007 0000 0
20 1 0 0005 0003 0
20 1 0 0009 0000 0
20 1 0 0088 0000 0
21 1 0 0006 0003 0
21 1 0 0100 0004 0
22 1 0 0004 0003 0

//--- compile.f
hdl/arrayPkg.sv
hdl/arrayAllocator.sv
hdl/arraySizeTable.sv
hdl/elementStore.sv
hdl/elementAlu.sv
hdl/arraySearch.sv
hdl/arrayController.sv
hdl/arrayMemory.sv
verif/tbArrayMemory.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tbArrayMemory -Mdir obj_dir &&
  ./obj_dir/VtbArrayMemory > sim.log 2>&1
grep -q "^Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
